/* verilog.f */
design/nice_isa_pkg.sv
design/nice_bus_pkg.sv
design/nice_inst_decode.sv
design/nice_config_regs.sv
design/nice_xfer_ctrl.sv
design/nice_top.sv
verif/nice_clk_gen.sv
verif/tb_nice_top.sv

/* Makefile */
TOOL       = verilator
TOP        = tb_nice_top
LINT_TOP   = nice_top
FILELIST   = verilog.f
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
OBJDIR     = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "no verdict found in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* verif/tb_nice_top.sv */
`timescale 1ns/100ps

module tb_nice_top;

    import nice_isa_pkg::*;
    import nice_bus_pkg::*;

    localparam int fetch_words    = default_fetch_words;
    localparam int store_words    = default_store_words;
    localparam int config_entries = default_config_entries;
    localparam int clk_period     = 20;
    localparam int drive_delay    = 2;
    localparam int mem_words      = 1024;
    localparam int n_entries      = 15;
    localparam logic [addr_width-1:0] err_addr = 32'h0000_0208;

    localparam int kind_config  = 0;
    localparam int kind_illegal = 1;
    localparam int kind_lbuf    = 2;
    localparam int kind_sbuf    = 3;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   req_valid;
    logic                                   req_ready;
    logic [inst_width-1:0]                  req_inst;
    logic [data_width-1:0]                  req_rs1;
    logic                                   rsp_valid;
    logic                                   rsp_ready;
    logic                                   rsp_err;
    logic                                   mem_cmd_valid;
    logic                                   mem_cmd_ready;
    logic [addr_width-1:0]                  mem_cmd_addr;
    logic                                   mem_cmd_read;
    logic [data_width-1:0]                  mem_cmd_wdata;
    logic                                   mem_rsp_valid;
    logic                                   mem_rsp_ready;
    logic [data_width-1:0]                  mem_rsp_rdata;
    logic                                   mem_rsp_err;
    logic                                   acc_cmd_valid;
    logic                                   acc_cmd_ready;
    logic [data_width-1:0]                  acc_cmd_data;
    logic                                   acc_rsp_valid;
    logic                                   acc_rsp_ready;
    logic [data_width-1:0]                  acc_rsp_data;
    logic                                   active;
    logic                                   mem_holdup;
    logic [config_entries*data_width-1:0]   config_regs;

    // Stimulus table
    logic [inst_width-1:0] tab_inst  [n_entries];
    logic [data_width-1:0] tab_rs1   [n_entries];
    logic                  tab_err   [n_entries];
    int                    tab_kind  [n_entries];
    logic                  tab_stall [n_entries];
    int                    tab_count = 0;

    logic [data_width-1:0] mem [mem_words];
    logic [addr_width-1:0] cmd_addr_q [$];
    logic                  cmd_read_q [$];
    logic [data_width-1:0] stream_q [$];
    logic [data_width-1:0] result_q [$];

    // Expected contents of the config bank
    logic [data_width-1:0] cfg_exp [config_entries];

    logic [31:0] rng_state = 32'd81489;
    logic        stall_en = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          entry_errors = 0;

    nice_clk_gen #(
        .period       (clk_period),
        .reset_cycles (10)
    ) clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    nice_top i_nice_top (.*);

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Ready or valid draw that always passes without back-pressure
    function automatic logic allow_cycle();
        logic [31:0] r;
        r = xorshift32();
        return !stall_en || (r[1:0] != 2'b00);
    endfunction

    function automatic logic [data_width-1:0] fill_word(input int idx);
        return (data_width'(idx) * 32'h9E37_79B1) ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [data_width-1:0] result_word(input int n, input int k);
        return {16'hC0DE, 8'(n), 8'(k)};
    endfunction

    function automatic logic [inst_width-1:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                                     input logic [6:0] op);
        return {f7, 5'd3, 5'd1, f3, 5'd2, op};
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            kind_config:  return "config";
            kind_illegal: return "illegal";
            kind_lbuf:    return "lbuf";
            default:      return "sbuf";
        endcase
    endfunction

    task automatic add_entry(input logic [inst_width-1:0] inst, input logic [data_width-1:0] rs1,
                             input logic err, input int kind, input logic stall);
        tab_inst[tab_count]  = inst;
        tab_rs1[tab_count]   = rs1;
        tab_err[tab_count]   = err;
        tab_kind[tab_count]  = kind;
        tab_stall[tab_count] = stall;
        tab_count++;
    endtask

    task automatic load_table();
        add_entry(r_type(func7_config_base, func3_buf, opcode_custom0), 32'h1111_0000, 0,
                  kind_config, 0);
        add_entry(r_type(func7_config_base + 7'd3, func3_buf, opcode_custom0), 32'hDEAD_BEEF, 0,
                  kind_config, 0);
        add_entry(r_type(func7_config_base + 7'd7, func3_buf, opcode_custom0), 32'h0000_7777, 0,
                  kind_config, 0);
        // Custom-1 slot, unknown func7, config index past the bank, wrong func3
        add_entry(r_type(func7_lbuf, func3_buf, 7'b0101011), 32'h0000_0100, 1, kind_illegal, 0);
        add_entry(r_type(7'd3, func3_buf, opcode_custom0), 32'h0000_0100, 1, kind_illegal, 0);
        add_entry(r_type(func7_config_base + 7'd8, func3_buf, opcode_custom0), 32'h5555_5555, 1,
                  kind_illegal, 0);
        add_entry(r_type(func7_lbuf, 3'b000, opcode_custom0), 32'h0000_0100, 1, kind_illegal, 0);
        add_entry(r_type(func7_lbuf, func3_buf, opcode_custom0), 32'h0000_0100, 0, kind_lbuf, 0);
        add_entry(r_type(func7_sbuf, func3_buf, opcode_custom0), 32'h0000_0800, 0, kind_sbuf, 0);
        // Covers the marked address
        add_entry(r_type(func7_lbuf, func3_buf, opcode_custom0), 32'h0000_0200, 1, kind_lbuf, 0);
        add_entry(r_type(func7_lbuf, func3_buf, opcode_custom0), 32'h0000_0140, 0, kind_lbuf, 1);
        add_entry(r_type(func7_sbuf, func3_buf, opcode_custom0), 32'h0000_0840, 0, kind_sbuf, 1);
        add_entry(r_type(func7_config_base + 7'd5, func3_buf, opcode_custom0), 32'hCAFE_0005, 0,
                  kind_config, 1);
        add_entry(r_type(func7_lbuf, func3_buf, opcode_custom0), 32'h0000_0180, 0, kind_lbuf, 1);
        add_entry(r_type(func7_sbuf, func3_buf, opcode_custom0), 32'h0000_0880, 0, kind_sbuf, 1);
    endtask

    task automatic report_problem(input string what);
        $display("[ERROR] %0t ns %s", $time, what);
        errors++;
        entry_errors++;
    endtask

    task automatic compare_config(input string name, input logic [data_width-1:0] got,
                                  input logic [data_width-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            errors++;
            entry_errors++;
        end
    endtask

    task automatic compare_err(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
            errors++;
            entry_errors++;
        end
    endtask

    task automatic compare_mem(input string name, input logic [data_width-1:0] got,
                               input logic [data_width-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            errors++;
            entry_errors++;
        end
    endtask

    task automatic compare_stream(input string name, input logic [data_width-1:0] got,
                                  input logic [data_width-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            errors++;
            entry_errors++;
        end
    endtask

    task automatic compare_addr(input string name, input logic [addr_width-1:0] got,
                                input logic [addr_width-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            errors++;
            entry_errors++;
        end
    endtask

    task automatic check_transfer(input int n, input int words, input logic read);
        logic [addr_width-1:0] addr;
        int                    idx;
        if (cmd_addr_q.size() != words)
            report_problem($sformatf("%0d memory commands seen, %0d expected",
                                     cmd_addr_q.size(), words));
        if (read && stream_q.size() != words)
            report_problem($sformatf("%0d stream words seen, %0d expected",
                                     stream_q.size(), words));
        for (int k = 0; k < words && k < cmd_addr_q.size(); k++) begin
            addr = tab_rs1[n] + addr_width'(k * word_bytes);
            idx  = int'(addr[11:2]);
            compare_addr($sformatf("mem_cmd_addr[%0d]", k), cmd_addr_q[k], addr);
            if (cmd_read_q[k] !== read)
                report_problem($sformatf("memory command %0d has the wrong direction", k));
            if (!read) begin
                compare_mem($sformatf("mem[%0d]", idx), mem[idx], result_word(n, k));
            end else if (k < stream_q.size()) begin
                compare_stream($sformatf("acc_cmd_data[%0d]", k), stream_q[k], fill_word(idx));
            end
        end
    endtask

    task automatic run_entry(input int n);
        logic got_err;
        int   k;
        int   cycles;
        entry_errors = 0;
        @(negedge clk);
        stall_en = tab_stall[n];
        cmd_addr_q.delete();
        cmd_read_q.delete();
        stream_q.delete();
        result_q.delete();
        if (tab_kind[n] == kind_sbuf) begin
            for (int j = 0; j < store_words; j++) result_q.push_back(result_word(n, j));
        end
        @(posedge clk);
        #(drive_delay);
        req_valid = 1'b1;
        req_inst  = tab_inst[n];
        req_rs1   = tab_rs1[n];
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        if (!active)
            report_problem("active was low while a request waited");
        #(drive_delay);
        req_valid = 1'b0;
        rsp_ready = allow_cycle();
        cycles = 0;
        @(posedge clk);
        while (!(rsp_valid && rsp_ready)) begin
            if (req_ready || !mem_holdup || !active)
                report_problem("controller looked idle before the response completed");
            if (cycles == 0 && tab_kind[n] <= kind_illegal && !rsp_valid)
                report_problem("rsp_valid did not rise in the cycle after acceptance");
            cycles++;
            #(drive_delay);
            rsp_ready = allow_cycle();
            @(posedge clk);
        end
        got_err = rsp_err;
        #(drive_delay);
        rsp_ready = 1'b0;

        compare_err("rsp_err", got_err, tab_err[n]);
        k = (tab_kind[n] == kind_config) ? int'(tab_inst[n][31:25]) - int'(func7_config_base) : -1;
        if (k >= 0)
            cfg_exp[k] = tab_rs1[n];
        if (tab_kind[n] <= kind_illegal) begin
            for (int j = 0; j < config_entries; j++) begin
                compare_config($sformatf("config_regs[%0d]", j),
                               config_regs[j*data_width +: data_width], cfg_exp[j]);
            end
            if (cmd_addr_q.size() != 0)
                report_problem($sformatf("%0d memory commands issued by a %s instruction",
                                         cmd_addr_q.size(), kind_name(tab_kind[n])));
        end else if (tab_kind[n] == kind_lbuf) begin
            check_transfer(n, fetch_words, 1'b1);
        end else begin
            check_transfer(n, store_words, 1'b0);
        end
        if (entry_errors == 0)
            $display("entry %0d %s: ok", n, kind_name(tab_kind[n]));
        else
            $display("entry %0d %s: %0d errors", n, kind_name(tab_kind[n]), entry_errors);
    endtask

    // Memory model with one outstanding command and a random response delay
    initial begin : memory_model
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] rdata;
        logic                  err;
        logic                  busy;
        logic                  rsp_taken;
        int                    delay;
        mem_cmd_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_rdata = '0;
        mem_rsp_err   = 1'b0;
        for (int i = 0; i < mem_words; i++) mem[i] = fill_word(i);
        busy  = 1'b0;
        rdata = '0;
        err   = 1'b0;
        delay = 0;
        forever begin
            @(posedge clk);
            rsp_taken = mem_rsp_valid && mem_rsp_ready;
            if (rsp_taken) busy = 1'b0;
            if (mem_cmd_valid && mem_cmd_ready) begin
                addr = mem_cmd_addr;
                cmd_addr_q.push_back(addr);
                cmd_read_q.push_back(mem_cmd_read);
                if (mem_cmd_read) begin
                    rdata = mem[addr[11:2]];
                end else begin
                    mem[addr[11:2]] = mem_cmd_wdata;
                    rdata = '0;
                end
                err   = (addr == err_addr);
                delay = int'(xorshift32() % 4);
                busy  = 1'b1;
            end
            #(drive_delay);
            if (rsp_taken) mem_rsp_valid = 1'b0;
            if (busy && !mem_rsp_valid) begin
                if (delay == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp_rdata = rdata;
                    mem_rsp_err   = err;
                end else begin
                    delay = delay - 1;
                end
            end
            mem_cmd_ready = !busy && allow_cycle();
        end
    end

    // Accelerator model as command sink and result source
    initial begin : accel_model
        logic taken;
        acc_cmd_ready = 1'b0;
        acc_rsp_valid = 1'b0;
        acc_rsp_data  = '0;
        forever begin
            @(posedge clk);
            if (acc_cmd_valid && acc_cmd_ready) stream_q.push_back(acc_cmd_data);
            taken = acc_rsp_valid && acc_rsp_ready;
            if (taken) void'(result_q.pop_front());
            #(drive_delay);
            if (taken) acc_rsp_valid = 1'b0;
            if (!acc_rsp_valid && result_q.size() > 0 && allow_cycle()) begin
                acc_rsp_valid = 1'b1;
                acc_rsp_data  = result_q[0];
            end
            acc_cmd_ready = allow_cycle();
        end
    end

    initial begin : watchdog
        #(n_entries * 200 * clk_period);
        $display("watchdog expired, the DUT stopped making progress");
        $display("test failed");
        $finish;
    end

    initial begin : main_sequence
        req_valid = 1'b0;
        req_inst  = '0;
        req_rs1   = '0;
        rsp_ready = 1'b0;
        load_table();
        @(posedge rst_n);
        repeat (2) @(posedge clk);
        for (int j = 0; j < config_entries; j++) begin
            compare_config($sformatf("config_regs[%0d] after reset", j),
                           config_regs[j*data_width +: data_width], '0);
            cfg_exp[j] = '0;
        end
        if (!req_ready || rsp_valid || mem_cmd_valid || mem_rsp_ready || acc_cmd_valid ||
            acc_rsp_ready || active || mem_holdup)
            report_problem("handshake outputs not idle after reset");
        for (int n = 0; n < n_entries; n++) run_entry(n);
        $display("entries %0d, checks %0d, errors %0d", n_entries, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verif/nice_clk_gen.sv */
`timescale 1ns/100ps

module nice_clk_gen #(
    parameter int period       = 20,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Release lands just after an edge, like the other stimulus
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

/* design/nice_top.sv */
`timescale 1ns/100ps

module nice_top #(
    parameter int fetch_words    = nice_bus_pkg::default_fetch_words,
    parameter int store_words    = nice_bus_pkg::default_store_words,
    parameter int config_entries = nice_bus_pkg::default_config_entries
) (
    input  logic                                               clk,
    input  logic                                               rst_n,

    input  logic                                               req_valid,
    output logic                                               req_ready,
    input  logic [nice_isa_pkg::inst_width-1:0]                req_inst,
    input  logic [nice_bus_pkg::data_width-1:0]                req_rs1,

    output logic                                               rsp_valid,
    input  logic                                               rsp_ready,
    output logic                                               rsp_err,

    output logic                                               mem_cmd_valid,
    input  logic                                               mem_cmd_ready,
    output logic [nice_bus_pkg::addr_width-1:0]                mem_cmd_addr,
    output logic                                               mem_cmd_read,
    output logic [nice_bus_pkg::data_width-1:0]                mem_cmd_wdata,

    input  logic                                               mem_rsp_valid,
    output logic                                               mem_rsp_ready,
    input  logic [nice_bus_pkg::data_width-1:0]                mem_rsp_rdata,
    input  logic                                               mem_rsp_err,

    output logic                                               acc_cmd_valid,
    input  logic                                               acc_cmd_ready,
    output logic [nice_bus_pkg::data_width-1:0]                acc_cmd_data,

    input  logic                                               acc_rsp_valid,
    output logic                                               acc_rsp_ready,
    input  logic [nice_bus_pkg::data_width-1:0]                acc_rsp_data,

    output logic                                               active,
    output logic                                               mem_holdup,
    output logic [config_entries*nice_bus_pkg::data_width-1:0] config_regs
);

    import nice_bus_pkg::*;

    logic                              op_config;
    logic                              op_lbuf;
    logic                              op_sbuf;
    logic                              op_illegal;
    logic [$clog2(config_entries)-1:0] config_index;
    logic                              cfg_write;
    logic [data_width-1:0]             cfg_wdata;

    nice_inst_decode #(
        .config_entries (config_entries)
    ) i_nice_inst_decode (
        .inst         (req_inst),
        .op_config    (op_config),
        .op_lbuf      (op_lbuf),
        .op_sbuf      (op_sbuf),
        .op_illegal   (op_illegal),
        .config_index (config_index)
    );

    nice_config_regs #(
        .config_entries (config_entries)
    ) i_nice_config_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_write    (cfg_write),
        .config_index (config_index),
        .wdata        (cfg_wdata),
        .config_regs  (config_regs)
    );

    nice_xfer_ctrl #(
        .fetch_words (fetch_words),
        .store_words (store_words)
    ) i_nice_xfer_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_rs1       (req_rs1),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp_err       (rsp_err),
        .op_config     (op_config),
        .op_lbuf       (op_lbuf),
        .op_sbuf       (op_sbuf),
        .op_illegal    (op_illegal),
        .cfg_write     (cfg_write),
        .cfg_wdata     (cfg_wdata),
        .mem_cmd_valid (mem_cmd_valid),
        .mem_cmd_ready (mem_cmd_ready),
        .mem_cmd_addr  (mem_cmd_addr),
        .mem_cmd_read  (mem_cmd_read),
        .mem_cmd_wdata (mem_cmd_wdata),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp_rdata (mem_rsp_rdata),
        .mem_rsp_err   (mem_rsp_err),
        .acc_cmd_valid (acc_cmd_valid),
        .acc_cmd_ready (acc_cmd_ready),
        .acc_cmd_data  (acc_cmd_data),
        .acc_rsp_valid (acc_rsp_valid),
        .acc_rsp_ready (acc_rsp_ready),
        .acc_rsp_data  (acc_rsp_data),
        .active        (active),
        .mem_holdup    (mem_holdup)
    );

endmodule

/* design/nice_xfer_ctrl.sv */
`timescale 1ns/100ps

module nice_xfer_ctrl #(
    parameter int fetch_words = nice_bus_pkg::default_fetch_words,
    parameter int store_words = nice_bus_pkg::default_store_words
) (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic                                req_valid,
    output logic                                req_ready,
    input  logic [nice_bus_pkg::data_width-1:0] req_rs1,

    output logic                                rsp_valid,
    input  logic                                rsp_ready,
    output logic                                rsp_err,

    input  logic                                op_config,
    input  logic                                op_lbuf,
    input  logic                                op_sbuf,
    input  logic                                op_illegal,

    output logic                                cfg_write,
    output logic [nice_bus_pkg::data_width-1:0] cfg_wdata,

    output logic                                mem_cmd_valid,
    input  logic                                mem_cmd_ready,
    output logic [nice_bus_pkg::addr_width-1:0] mem_cmd_addr,
    output logic                                mem_cmd_read,
    output logic [nice_bus_pkg::data_width-1:0] mem_cmd_wdata,

    input  logic                                mem_rsp_valid,
    output logic                                mem_rsp_ready,
    input  logic [nice_bus_pkg::data_width-1:0] mem_rsp_rdata,
    input  logic                                mem_rsp_err,

    output logic                                acc_cmd_valid,
    input  logic                                acc_cmd_ready,
    output logic [nice_bus_pkg::data_width-1:0] acc_cmd_data,

    input  logic                                acc_rsp_valid,
    output logic                                acc_rsp_ready,
    input  logic [nice_bus_pkg::data_width-1:0] acc_rsp_data,

    output logic                                active,
    output logic                                mem_holdup
);

    import nice_bus_pkg::*;

    localparam int max_words = (fetch_words > store_words) ? fetch_words : store_words;
    localparam int count_w   = $clog2(max_words + 1);

    localparam logic [2:0] st_idle       = 3'd0;
    localparam logic [2:0] st_respond    = 3'd1;
    localparam logic [2:0] st_load_cmd   = 3'd2;
    localparam logic [2:0] st_load_wait  = 3'd3;
    localparam logic [2:0] st_stream_out = 3'd4;
    localparam logic [2:0] st_stream_in  = 3'd5;
    localparam logic [2:0] st_store_cmd  = 3'd6;
    localparam logic [2:0] st_store_wait = 3'd7;

    logic [2:0]            state;
    logic [count_w-1:0]    word_count;
    logic                  err_q;
    logic [addr_width-1:0] addr_q;
    logic [data_width-1:0] data_q;
    logic                  accept;
    logic                  last_fetch;
    logic                  last_store;

    assign accept     = req_valid && req_ready;
    assign last_fetch = (word_count == count_w'(fetch_words - 1));
    assign last_store = (word_count == count_w'(store_words - 1));

    // Config writes land on the accept edge
    assign cfg_write = accept && op_config;
    assign cfg_wdata = req_rs1;

    // Handshake outputs come straight from the state
    assign req_ready     = (state == st_idle);
    assign rsp_valid     = (state == st_respond);
    assign rsp_err       = err_q;
    assign mem_cmd_valid = (state == st_load_cmd) || (state == st_store_cmd);
    assign mem_cmd_read  = (state == st_load_cmd);
    assign mem_cmd_addr  = addr_q;
    assign mem_cmd_wdata = data_q;
    assign mem_rsp_ready = (state == st_load_wait) || (state == st_store_wait);
    assign acc_cmd_valid = (state == st_stream_out);
    assign acc_cmd_data  = data_q;
    assign acc_rsp_ready = (state == st_stream_in);

    assign mem_holdup = (state != st_idle);
    assign active     = (state != st_idle) || req_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            word_count <= '0;
            err_q      <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        word_count <= '0;
                        err_q      <= op_illegal;
                        if (op_lbuf) begin
                            state <= st_load_cmd;
                        end else if (op_sbuf) begin
                            state <= st_stream_in;
                        end else begin
                            state <= st_respond;
                        end
                    end
                end
                st_respond: begin
                    if (rsp_ready) begin
                        state <= st_idle;
                    end
                end
                st_load_cmd: begin
                    if (mem_cmd_ready) begin
                        state <= st_load_wait;
                    end
                end
                st_load_wait: begin
                    if (mem_rsp_valid) begin
                        err_q <= err_q | mem_rsp_err;
                        state <= st_stream_out;
                    end
                end
                st_stream_out: begin
                    if (acc_cmd_ready) begin
                        if (last_fetch) begin
                            state <= st_respond;
                        end else begin
                            word_count <= word_count + 1'b1;
                            state      <= st_load_cmd;
                        end
                    end
                end
                st_stream_in: begin
                    if (acc_rsp_valid) begin
                        state <= st_store_cmd;
                    end
                end
                st_store_cmd: begin
                    if (mem_cmd_ready) begin
                        state <= st_store_wait;
                    end
                end
                st_store_wait: begin
                    if (mem_rsp_valid) begin
                        err_q <= err_q | mem_rsp_err;
                        if (last_store) begin
                            state <= st_respond;
                        end else begin
                            word_count <= word_count + 1'b1;
                            state      <= st_stream_in;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Address and word buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= addr_width'(req_rs1);
        end else if ((state == st_stream_out && acc_cmd_ready && !last_fetch) ||
                     (state == st_store_wait && mem_rsp_valid && !last_store)) begin
            addr_q <= addr_q + addr_width'(word_bytes);
        end

        if (state == st_load_wait && mem_rsp_valid) begin
            data_q <= mem_rsp_rdata;
        end else if (state == st_stream_in && acc_rsp_valid) begin
            data_q <= acc_rsp_data;
        end
    end

    // A memory command stays put until the bus takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_cmd_valid && !mem_cmd_ready |=> mem_cmd_valid && $stable(mem_cmd_addr) &&
            $stable(mem_cmd_read) && $stable(mem_cmd_wdata))
        else $error("memory command changed before ready");

    // Same for the accelerator command stream
    assert property (@(posedge clk) disable iff (!rst_n)
        acc_cmd_valid && !acc_cmd_ready |=> acc_cmd_valid && $stable(acc_cmd_data))
        else $error("accelerator command changed before ready");

endmodule

/* design/nice_config_regs.sv */
`timescale 1ns/100ps

module nice_config_regs #(
    parameter int config_entries = nice_bus_pkg::default_config_entries
) (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                cfg_write,
    input  logic [$clog2(config_entries)-1:0]                   config_index,
    input  logic [nice_bus_pkg::data_width-1:0]                 wdata,
    output logic [config_entries*nice_bus_pkg::data_width-1:0]  config_regs
);

    import nice_bus_pkg::*;

    // Entry k occupies word k of the packed output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            config_regs <= '0;
        end else if (cfg_write) begin
            config_regs[config_index*data_width +: data_width] <= wdata;
        end
    end

    // Decoder range check must keep writes inside the bank
    assert property (@(posedge clk) disable iff (!rst_n)
        cfg_write |-> (config_index < config_entries))
        else $error("config write to index %0d outside bank", config_index);

endmodule

/* design/nice_inst_decode.sv */
`timescale 1ns/100ps

module nice_inst_decode #(
    parameter int config_entries = nice_bus_pkg::default_config_entries
) (
    input  logic [nice_isa_pkg::inst_width-1:0] inst,
    output logic                                op_config,
    output logic                                op_lbuf,
    output logic                                op_sbuf,
    output logic                                op_illegal,
    output logic [$clog2(config_entries)-1:0]   config_index
);

    import nice_isa_pkg::*;

    localparam int idx_w = $clog2(config_entries);

    logic [6:0] opcode;
    logic [2:0] func3;
    logic [6:0] func7;
    logic       is_buf;
    logic [6:0] config_offset;
    logic       config_hit;

    // R-type fields
    assign opcode = inst[6:0];
    assign func3  = inst[14:12];
    assign func7  = inst[31:25];

    assign is_buf = (opcode == opcode_custom0) && (func3 == func3_buf);

    // Config range starts at the base code
    assign config_offset = func7 - func7_config_base;
    assign config_hit    = (func7 >= func7_config_base) && (config_offset < config_entries);

    assign op_config = is_buf && config_hit;
    assign op_lbuf   = is_buf && (func7 == func7_lbuf);
    assign op_sbuf   = is_buf && (func7 == func7_sbuf);

    // Anything else is rejected with an error response
    assign op_illegal = !(op_config || op_lbuf || op_sbuf);

    assign config_index = config_offset[idx_w-1:0];

endmodule

/* design/nice_bus_pkg.sv */
package nice_bus_pkg;

    // Data, stream and config word width
    parameter int data_width = 32;

    // Memory address width
    parameter int addr_width = 32;

    // Address step between consecutive words
    parameter int word_bytes = 4;

    // Transfer lengths in words
    parameter int default_fetch_words = 6;
    parameter int default_store_words = 4;

    // Size of the config register bank
    parameter int default_config_entries = 8;

endpackage

/* design/nice_isa_pkg.sv */
package nice_isa_pkg;

    // Instruction word
    parameter int inst_width = 32;

    // Only the custom-0 slot is decoded
    parameter logic [6:0] opcode_custom0 = 7'b0001011;

    // Shared by config, lbuf and sbuf
    parameter logic [2:0] func3_buf = 3'b010;

    // Transfer operations
    parameter logic [6:0] func7_lbuf = 7'd1;
    parameter logic [6:0] func7_sbuf = 7'd2;

    // Config entry k sits at base plus k
    parameter logic [6:0] func7_config_base = 7'd6;

endpackage
